// ==== design/icache_data_array.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_data_array (
	input  logic                                   i_clk,
	input  logic                                   i_ren,
	input  logic [`ICACHE_IDX_W+`ICACHE_OFF_W-1:0] i_raddr, // {index, offset}
	input  logic                                   i_wen,
	input  icache_pkg::way_onehot_t                i_wway,
	input  icache_pkg::set_index_t                 i_widx,
	input  icache_pkg::word_offset_t               i_woff,
	input  logic [31:0]                            i_wdata,
	input  icache_pkg::way_t                       i_hit_way,
	output logic [31:0]                            o_rdata
);

	localparam int DEPTH = `ICACHE_SETS * `ICACHE_WORDS;

	logic [31:0] w_rword [`ICACHE_WAYS];

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		logic [31:0] mem [DEPTH];
		logic [31:0] r_word;

		always_ff @(posedge i_clk) begin
			if (i_wen && i_wway[w]) begin
				mem[{i_widx, i_woff}] <= i_wdata; // refill beat
			end
			if (i_ren) begin
				r_word <= mem[i_raddr];
			end
		end

		assign w_rword[w] = r_word;
	end

	assign o_rdata = w_rword[i_hit_way];

endmodule

// ==== design/icache_pkg.sv ====
`include "icache_params.svh"

package icache_pkg;

	typedef enum logic [2:0] {
		invalidating,
		idle,
		receiving,
		refill
	} icache_state_e;

	typedef struct packed {
		logic                     valid;
		logic [`ICACHE_TAG_W-1:0] tag;
	} tag_entry_t;

	typedef logic [`ICACHE_IDX_W-1:0] set_index_t;
	typedef logic [`ICACHE_OFF_W-1:0] word_offset_t;

	typedef logic [1:0] way_t;
	typedef logic [`ICACHE_WAYS-1:0] way_onehot_t;

	// tree bits: [1] root, [0] ways 0-1, [2] ways 2-3
	typedef logic [2:0] plru_t;

endpackage

// ==== design/icache_plru.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_plru (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  icache_pkg::set_index_t  i_idx,
	input  logic                    i_hit,
	input  icache_pkg::way_t        i_hit_way,
	input  logic                    i_miss,
	output icache_pkg::way_t        o_victim,
	output icache_pkg::way_onehot_t o_victim_onehot
);

	icache_pkg::plru_t [`ICACHE_SETS-1:0] r_tree;
	icache_pkg::plru_t                    w_cur;
	icache_pkg::plru_t                    w_next;
	icache_pkg::way_t                     w_acc;

	assign w_cur = r_tree[i_idx];

	always_comb begin
		if (w_cur[1]) begin
			o_victim = w_cur[0] ? 2'd0 : 2'd1;
		end else begin
			o_victim = w_cur[2] ? 2'd2 : 2'd3;
		end
	end

	assign o_victim_onehot = icache_pkg::way_onehot_t'(1) << o_victim;

	// a miss touches the way it is about to replace
	assign w_acc = i_hit ? i_hit_way : o_victim;

	// point away from the accessed way, other half untouched
	always_comb begin
		w_next = w_cur;
		case (w_acc)
			2'd0: w_next[1:0] = 2'b00;
			2'd1: w_next[1:0] = 2'b01;
			2'd2: w_next[2:1] = 2'b01;
			default: w_next[2:1] = 2'b11;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_tree <= '0;
		end else if (i_hit || i_miss) begin
			r_tree[i_idx] <= w_next;
		end
	end

endmodule

// ==== design/icache_refill_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_refill_ctrl (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_valid2,
	input  logic [`ICACHE_ADDR_W-1:0] i_phy_addr,
	input  logic                      i_hit,
	input  icache_pkg::set_index_t    i_idx,
	input  icache_pkg::way_onehot_t   i_victim,
	input  logic [31:0]               i_hit_data,
	input  mem_bus_pkg::mem_read_resp i_resp,
	output logic                      o_sweep_en,
	output icache_pkg::set_index_t    o_sweep_idx,
	output logic                      o_fill_en,
	output icache_pkg::set_index_t    o_fill_idx,
	output logic [`ICACHE_TAG_W-1:0]  o_fill_tag,
	output icache_pkg::way_onehot_t   o_fill_way,
	output logic                      o_beat_wen,
	output icache_pkg::word_offset_t  o_beat_off,
	output logic                      o_lookup,
	output logic                      o_miss,
	output logic                      o_valid,
	output logic [31:0]               o_mdata_data,
	output logic                      o_inn_stall,
	output logic                      o_mem_read_we,
	output mem_bus_pkg::mem_read_req  o_memread_req
);

	localparam int LINE_LSB = `ICACHE_OFF_W + 2;

	icache_pkg::icache_state_e r_state;
	icache_pkg::icache_state_e w_next;
	icache_pkg::set_index_t    r_sweep_cnt;
	icache_pkg::word_offset_t  r_beat;

	// miss context
	logic [`ICACHE_TAG_W-1:0]  r_tag;
	icache_pkg::set_index_t    r_idx;
	icache_pkg::word_offset_t  r_off;
	icache_pkg::way_onehot_t   r_way;

	logic w_beat;
	logic w_crit; // requested word is on the bus

	assign o_lookup = i_valid2 && (r_state == icache_pkg::idle);
	assign o_miss   = o_lookup && !i_hit;
	assign w_beat   = (r_state == icache_pkg::receiving) && i_resp.valid;
	assign w_crit   = w_beat && (r_beat == r_off);

	always_comb begin
		w_next = r_state;
		case (r_state)
			icache_pkg::invalidating: begin
				if (&r_sweep_cnt) begin
					w_next = icache_pkg::idle;
				end
			end
			icache_pkg::idle: begin
				if (o_miss) begin
					w_next = icache_pkg::receiving;
				end
			end
			icache_pkg::receiving: begin
				if (w_beat && i_resp.last) begin
					w_next = icache_pkg::refill;
				end
			end
			icache_pkg::refill: w_next = icache_pkg::idle;
			default: w_next = icache_pkg::invalidating;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state     <= icache_pkg::invalidating;
			r_sweep_cnt <= '0;
			r_beat      <= '0;
		end else begin
			r_state <= w_next;
			if (r_state == icache_pkg::invalidating) begin
				r_sweep_cnt <= r_sweep_cnt + 1'b1;
			end
			if (o_miss) begin
				r_beat <= '0;
			end else if (w_beat) begin
				r_beat <= r_beat + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_miss) begin
			r_tag <= i_phy_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
			r_idx <= i_idx;
			r_off <= i_phy_addr[LINE_LSB-1:2];
			r_way <= i_victim;
		end
	end

	assign o_sweep_en  = (r_state == icache_pkg::invalidating);
	assign o_sweep_idx = r_sweep_cnt;

	assign o_fill_en  = w_beat && i_resp.last; // tag goes in with the last beat
	assign o_fill_idx = r_idx;
	assign o_fill_tag = r_tag;
	assign o_fill_way = r_way;
	assign o_beat_wen = w_beat;
	assign o_beat_off = r_beat;

	assign o_valid      = (o_lookup && i_hit) || w_crit;
	assign o_mdata_data = w_crit ? i_resp.data : i_hit_data;
	assign o_inn_stall  = (r_state != icache_pkg::idle) || o_miss;

	assign o_mem_read_we           = o_miss;
	assign o_memread_req.startaddr = {i_phy_addr[`ICACHE_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
	assign o_memread_req.len       = 3'(`ICACHE_WORDS - 1);

endmodule

// ==== design/icache_tag_array.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tag_array (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_ren,
	input  icache_pkg::set_index_t    i_raddr,
	input  logic [`ICACHE_ADDR_W-1:0] i_phy_addr,
	input  logic                      i_lookup,
	input  logic                      i_sweep_en,
	input  icache_pkg::set_index_t    i_sweep_idx,
	input  logic                      i_fill_en,
	input  icache_pkg::set_index_t    i_fill_idx,
	input  logic [`ICACHE_TAG_W-1:0]  i_fill_tag,
	input  icache_pkg::way_onehot_t   i_fill_way,
	output logic                      o_hit,
	output icache_pkg::way_t          o_hit_way,
	output icache_pkg::way_onehot_t   o_hit_onehot,
	output icache_pkg::set_index_t    o_idx
);

	logic                     r_rd_valid; // a stage-one read happened last cycle
	logic [`ICACHE_TAG_W-1:0] w_ptag;

	assign w_ptag = i_phy_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_pkg::tag_entry_t mem [`ICACHE_SETS];
		icache_pkg::tag_entry_t r_rtag;

		always_ff @(posedge i_clk) begin
			if (i_sweep_en) begin
				mem[i_sweep_idx] <= '0;
			end else if (i_fill_en && i_fill_way[w]) begin
				mem[i_fill_idx] <= {1'b1, i_fill_tag};
			end
			if (i_ren) begin
				r_rtag <= mem[i_raddr];
			end
		end

		assign o_hit_onehot[w] = i_lookup && r_rd_valid && r_rtag.valid && (r_rtag.tag == w_ptag);
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_rd_valid <= 1'b0;
			o_idx      <= '0;
		end else begin
			r_rd_valid <= i_ren;
			if (i_ren) begin
				o_idx <= i_raddr;
			end
		end
	end

	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (o_hit_onehot[w]) begin
				o_hit_way = icache_pkg::way_t'(w);
			end
		end
	end

	assign o_hit = |o_hit_onehot;

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_top (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_valid1,
	input  logic [`ICACHE_ADDR_W-1:0] i_va,
	input  logic                      i_valid2,
	input  logic [`ICACHE_ADDR_W-1:0] i_phy_addr,
	output logic                      o_valid,
	output logic [31:0]               o_mdata_data,
	output logic                      o_inn_stall,
	output logic                      o_mem_read_we,
	output mem_bus_pkg::mem_read_req  o_memread_req,
	input  mem_bus_pkg::mem_read_resp i_resp
);

	localparam int IDX_LSB = `ICACHE_OFF_W + 2;

	logic                     w_sweep_en;
	icache_pkg::set_index_t   w_sweep_idx;
	logic                     w_fill_en;
	icache_pkg::set_index_t   w_fill_idx;
	logic [`ICACHE_TAG_W-1:0] w_fill_tag;
	icache_pkg::way_onehot_t  w_fill_way;
	logic                     w_beat_wen;
	icache_pkg::word_offset_t w_beat_off;
	logic                     w_lookup;
	logic                     w_miss;
	logic                     w_hit;
	icache_pkg::way_t         w_hit_way;
	icache_pkg::set_index_t   w_idx;
	icache_pkg::way_onehot_t  w_victim_onehot;
	logic [31:0]              w_hit_data;

	icache_tag_array u_tag_array (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_ren        (i_valid1),
		.i_raddr      (i_va[IDX_LSB +: `ICACHE_IDX_W]),
		.i_phy_addr   (i_phy_addr),
		.i_lookup     (w_lookup),
		.i_sweep_en   (w_sweep_en),
		.i_sweep_idx  (w_sweep_idx),
		.i_fill_en    (w_fill_en),
		.i_fill_idx   (w_fill_idx),
		.i_fill_tag   (w_fill_tag),
		.i_fill_way   (w_fill_way),
		.o_hit        (w_hit),
		.o_hit_way    (w_hit_way),
		.o_hit_onehot (),
		.o_idx        (w_idx)
	);

	icache_data_array u_data_array (
		.i_clk     (i_clk),
		.i_ren     (i_valid1),
		.i_raddr   (i_va[IDX_LSB+`ICACHE_IDX_W-1:2]), // index and word offset
		.i_wen     (w_beat_wen),
		.i_wway    (w_fill_way),
		.i_widx    (w_fill_idx),
		.i_woff    (w_beat_off),
		.i_wdata   (i_resp.data),
		.i_hit_way (w_hit_way),
		.o_rdata   (w_hit_data)
	);

	icache_plru u_plru (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_idx           (w_idx),
		.i_hit           (w_hit),
		.i_hit_way       (w_hit_way),
		.i_miss          (w_miss),
		.o_victim        (),
		.o_victim_onehot (w_victim_onehot)
	);

	icache_refill_ctrl u_refill_ctrl (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_valid2      (i_valid2),
		.i_phy_addr    (i_phy_addr),
		.i_hit         (w_hit),
		.i_idx         (w_idx),
		.i_victim      (w_victim_onehot),
		.i_hit_data    (w_hit_data),
		.i_resp        (i_resp),
		.o_sweep_en    (w_sweep_en),
		.o_sweep_idx   (w_sweep_idx),
		.o_fill_en     (w_fill_en),
		.o_fill_idx    (w_fill_idx),
		.o_fill_tag    (w_fill_tag),
		.o_fill_way    (w_fill_way),
		.o_beat_wen    (w_beat_wen),
		.o_beat_off    (w_beat_off),
		.o_lookup      (w_lookup),
		.o_miss        (w_miss),
		.o_valid       (o_valid),
		.o_mdata_data  (o_mdata_data),
		.o_inn_stall   (o_inn_stall),
		.o_mem_read_we (o_mem_read_we),
		.o_memread_req (o_memread_req)
	);

endmodule

// ==== design/mem_bus_pkg.sv ====
`include "icache_params.svh"

package mem_bus_pkg;

	// burst read request, len is beats minus one
	typedef struct packed {
		logic [`ICACHE_ADDR_W-1:0] startaddr;
		logic [2:0]                len;
	} mem_read_req;

	// one response beat
	typedef struct packed {
		logic        valid;
		logic        last; // final beat of the burst
		logic [31:0] data;
	} mem_read_resp;

endpackage

// ==== dv/icache_mem_model.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_mem_model (
	input  logic                      i_clk,
	input  logic                      i_req_we,
	input  mem_bus_pkg::mem_read_req  i_req,
	output mem_bus_pkg::mem_read_resp o_resp
);

	localparam int          LATENCY = 2;
	localparam logic [31:0] SEED    = 32'h7126c0c1;
	localparam logic [31:0] TAPS    = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

	logic [31:0] lfsr = SEED;

	// galois form, the bit taken is the new lsb
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ TAPS;
		end
		return n;
	endfunction

	initial begin
		logic [31:0] base;
		logic [2:0]  last_beat;
		o_resp = '0;
		forever begin
			@(posedge i_clk);
			if (i_req_we === 1'b1) begin
				base      = i_req.startaddr;
				last_beat = i_req.len;
				repeat (LATENCY) @(posedge i_clk);
				for (int b = 0; b <= int'(last_beat); b++) begin
					lfsr = lfsr_step(lfsr);
					if (lfsr[0]) begin
						@(negedge i_clk);
						o_resp = '0; // gap cycle
						@(posedge i_clk);
					end
					@(negedge i_clk);
					o_resp.valid = 1'b1;
					o_resp.last  = (b == int'(last_beat));
					o_resp.data  = (base + 32'(4 * b)) ^ 32'h5a5a0000;
					@(posedge i_clk);
				end
				@(negedge i_clk);
				o_resp = '0;
			end
		end
	end

endmodule

// ==== dv/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tb;

	localparam int HALF   = 50;
	localparam int SETTLE = 25; // sample in the middle of the low phase
	localparam int NUM    = 29;
	localparam int LIMIT  = NUM * 40 + 200;

	typedef struct packed {
		logic [31:0] addr;
		logic        miss;
		logic [2:0]  test;
	} stim_t;

	logic                      i_clk;
	logic                      i_rst;
	logic                      i_valid1;
	logic [31:0]               i_va;
	logic                      i_valid2;
	logic [31:0]               i_phy_addr;
	logic                      o_valid;
	logic [31:0]               o_mdata_data;
	logic                      o_inn_stall;
	logic                      o_mem_read_we;
	mem_bus_pkg::mem_read_req  o_memread_req;
	mem_bus_pkg::mem_read_resp i_resp;

	stim_t stim [NUM] = '{
		'{32'h00010040, 1'b1, 3'd1}, // cold misses
		'{32'h0002376c, 1'b1, 3'd1},
		'{32'h00010040, 1'b0, 3'd2},
		'{32'h00010058, 1'b0, 3'd2}, // same line and another word
		'{32'h0002376c, 1'b0, 3'd2},
		'{32'h00003200, 1'b1, 3'd3}, // one miss per word offset
		'{32'h00003224, 1'b1, 3'd3},
		'{32'h00003248, 1'b1, 3'd3},
		'{32'h0000326c, 1'b1, 3'd3},
		'{32'h00003290, 1'b1, 3'd3},
		'{32'h000032b4, 1'b1, 3'd3},
		'{32'h000032d8, 1'b1, 3'd3},
		'{32'h000032fc, 1'b1, 3'd3},
		'{32'h00003200, 1'b0, 3'd4}, // pipelined hits
		'{32'h00003224, 1'b0, 3'd4},
		'{32'h0000324c, 1'b0, 3'd4},
		'{32'h000032e0, 1'b0, 3'd4},
		'{32'h00010044, 1'b0, 3'd4},
		'{32'h00100124, 1'b1, 3'd5}, // set 9 with tags 0x100 to 0x500
		'{32'h00200134, 1'b1, 3'd5},
		'{32'h00300128, 1'b1, 3'd5},
		'{32'h0040013c, 1'b1, 3'd5},
		'{32'h00100124, 1'b0, 3'd5},
		'{32'h0050012c, 1'b1, 3'd5}, // evicts tag 0x200
		'{32'h00100124, 1'b0, 3'd5},
		'{32'h00300128, 1'b0, 3'd5},
		'{32'h0040013c, 1'b0, 3'd5},
		'{32'h00200134, 1'b1, 3'd5},
		'{32'h0050012c, 1'b0, 3'd5}
	};

	// reference model of the tags and tree bits
	icache_pkg::tag_entry_t model_tags [`ICACHE_SETS][`ICACHE_WAYS];
	icache_pkg::plru_t      model_tree [`ICACHE_SETS];

	int cycles = 0;
	int errors = 0;
	int cur_entry;

	icache_top u_icache_top (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_valid1      (i_valid1),
		.i_va          (i_va),
		.i_valid2      (i_valid2),
		.i_phy_addr    (i_phy_addr),
		.o_valid       (o_valid),
		.o_mdata_data  (o_mdata_data),
		.o_inn_stall   (o_inn_stall),
		.o_mem_read_we (o_mem_read_we),
		.o_memread_req (o_memread_req),
		.i_resp        (i_resp)
	);

	icache_mem_model u_mem_model (
		.i_clk    (i_clk),
		.i_req_we (o_mem_read_we),
		.i_req    (o_memread_req),
		.o_resp   (i_resp)
	);

	// way holding the line or -1
	function automatic int find_way(input logic [31:0] addr);
		int way;
		way = -1;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_tags[addr[11:5]][w].valid && model_tags[addr[11:5]][w].tag == addr[31:12]) begin
				way = w;
			end
		end
		return way;
	endfunction

	function automatic int pick_victim(input icache_pkg::plru_t t);
		if (t[1]) begin
			return t[0] ? 0 : 1;
		end
		return t[2] ? 2 : 3;
	endfunction

	// tree bits on the path turn away from the accessed way
	function automatic icache_pkg::plru_t touch(input icache_pkg::plru_t t, input int way);
		icache_pkg::plru_t n;
		n = t;
		n[1] = (way >= 2);
		if (way < 2) begin
			n[0] = (way == 1);
		end else begin
			n[2] = (way == 3);
		end
		return n;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
	endfunction

	task automatic note_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAILED %s = %h, expected %h (entry %0d)", name, got, exp, cur_entry);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("entry %0d: %s", cur_entry, what);
		errors++;
	endtask

	initial begin
		i_clk = 1'b0;
		forever #HALF i_clk = ~i_clk;
	end

	initial begin
		while (cycles <= LIMIT) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the cache stopped responding", cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int          sweep;
		int          way;
		int          words_seen;
		int          test_start;
		int          test_len;
		logic [31:0] addr;
		logic [6:0]  set;
		logic        predict_miss;

		i_rst      = 1'b1;
		i_valid1   = 1'b0;
		i_va       = '0;
		i_valid2   = 1'b0;
		i_phy_addr = '0;
		cur_entry  = -1;
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			model_tree[s] = '0;
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				model_tags[s][w] = '0;
			end
		end

		repeat (7) begin
			@(negedge i_clk);
			#SETTLE;
			if (o_inn_stall !== 1'b1) note_mismatch("o_inn_stall", 32'(o_inn_stall), 32'd1);
			if (o_valid !== 1'b0) note_mismatch("o_valid", 32'(o_valid), 32'd0);
			if (o_mem_read_we !== 1'b0) begin
				note_mismatch("o_mem_read_we", 32'(o_mem_read_we), 32'd0);
			end
		end
		@(negedge i_clk);
		i_rst = 1'b0;
		sweep = 0;
		do begin
			@(negedge i_clk);
			#SETTLE;
			sweep++;
		end while (o_inn_stall === 1'b1);
		if (sweep != `ICACHE_SETS) begin
			report_problem($sformatf("valid sweep took %0d cycles instead of 128", sweep));
		end
		$display("reset: sweep took %0d cycles, %0d errors", sweep, errors);

		@(negedge i_clk);
		i_valid1   = 1'b1;
		i_va       = stim[0].addr;
		test_start = errors;
		test_len   = 0;
		for (int k = 0; k < NUM; k++) begin
			cur_entry    = k;
			addr         = stim[k].addr;
			set          = addr[11:5];
			way          = find_way(addr);
			predict_miss = (way < 0);
			if (predict_miss != stim[k].miss) begin
				report_problem("stimulus table and reference model disagree on hit or miss");
			end

			@(negedge i_clk);
			i_valid2   = 1'b1;
			i_phy_addr = addr;
			i_valid1   = 1'b0;
			if (k + 1 < NUM) begin
				i_valid1 = 1'b1; // next request enters stage one
				i_va     = stim[k + 1].addr;
			end
			#SETTLE;

			if (!predict_miss) begin
				model_tree[set] = touch(model_tree[set], way);
				if (o_valid !== 1'b1) note_mismatch("o_valid", 32'(o_valid), 32'd1);
				if (o_mdata_data !== expected_word(addr)) begin
					note_mismatch("o_mdata_data", o_mdata_data, expected_word(addr));
				end
				if (o_mem_read_we !== 1'b0) note_mismatch("o_mem_read_we", 32'(o_mem_read_we), 32'd0);
				if (o_inn_stall !== 1'b0) note_mismatch("o_inn_stall", 32'(o_inn_stall), 32'd0);
			end else begin
				way                  = pick_victim(model_tree[set]);
				model_tree[set]      = touch(model_tree[set], way);
				model_tags[set][way] = '{valid: 1'b1, tag: addr[31:12]};
				if (o_mem_read_we !== 1'b1) note_mismatch("o_mem_read_we", 32'(o_mem_read_we), 32'd1);
				if (o_memread_req.startaddr !== {addr[31:5], 5'b0}) begin
					note_mismatch("o_memread_req.startaddr", o_memread_req.startaddr,
						{addr[31:5], 5'b0});
				end
				if (o_memread_req.len !== 3'd7) note_mismatch("o_memread_req.len",
					32'(o_memread_req.len), 32'd7);
				if (o_valid !== 1'b0) note_mismatch("o_valid", 32'(o_valid), 32'd0);
				if (o_inn_stall !== 1'b1) note_mismatch("o_inn_stall", 32'(o_inn_stall), 32'd1);

				words_seen = 0;
				do begin
					@(negedge i_clk);
					i_valid1 = 1'b0;
					i_valid2 = 1'b0;
					#SETTLE;
					if (o_mem_read_we !== 1'b0) begin
						note_mismatch("o_mem_read_we", 32'(o_mem_read_we), 32'd0);
					end
					if (o_valid === 1'b1) begin
						words_seen++;
						if (o_mdata_data !== expected_word(addr)) begin
							note_mismatch("o_mdata_data", o_mdata_data, expected_word(addr));
						end
					end
				end while (o_inn_stall === 1'b1);
				if (words_seen != 1) begin
					report_problem($sformatf("refill returned the word %0d times", words_seen));
				end
				if (k + 1 < NUM) begin
					@(negedge i_clk);
					i_valid1 = 1'b1; // reissue the request dropped in the miss cycle
					i_va     = stim[k + 1].addr;
				end
			end

			test_len++;
			if (k == NUM - 1 || stim[k + 1 < NUM ? k + 1 : k].test != stim[k].test) begin
				$display("test %0d: %0d accesses, %0d errors", stim[k].test, test_len,
					errors - test_start);
				test_start = errors;
				test_len   = 0;
			end
		end

		@(negedge i_clk);
		i_valid1 = 1'b0;
		i_valid2 = 1'b0;
		$display("done: %0d accesses, %0d errors in %0d cycles", NUM, errors, cycles);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== include/icache_params.svh ====
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// address and line geometry
`define ICACHE_ADDR_W 32
`define ICACHE_TAG_W  20
`define ICACHE_WORDS  8

// organisation
`define ICACHE_WAYS   4
`define ICACHE_SETS   128

// field widths, word offset sits above the byte offset
`define ICACHE_OFF_W  3
`define ICACHE_IDX_W  7

`endif

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module icache_tb -f verilog.f -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -F "RESULT: PASS" > /dev/null &&
echo "icache simulation passed" ||
{ echo "icache simulation failed"; exit 1; }

// ==== verilog.f ====
+incdir+include
design/mem_bus_pkg.sv
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_plru.sv
design/icache_refill_ctrl.sv
design/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv
